/* sources.f */
+incdir+verilog
verilog/fe_pkg.sv
verilog/idecoder.sv
verilog/pipeline_unit.sv
verilog/fetch_unit.sv
verilog/frontend_top.sv
verif/frontend_chk.sv
verif/frontend_tb.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module frontend_tb -f sources.f -o frontend_sim \
    || { echo "Build failed"; exit 1; }
./obj_dir/frontend_sim > sim.log 2>&1
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

/* verif/frontend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fe_settings.svh"

module frontend_tb;
    import fe_pkg::*;

    // Roughly 500 cycles of tests at worst memory latency
    localparam int TIMEOUT_CYCLES = 2000;

    logic   clk = 1'b0;
    logic   rst_n = 1'b0;
    logic   stall = 1'b0;
    logic   redirect = 1'b0;
    addr_t  redirect_target = '0;
    logic   imem_ack = 1'b0;
    instr_t imem_rdata = '0;

    logic imem_req;
    addr_t imem_addr;
    instr_t instr_out;
    cond_t cond;
    opcode_t opcode;
    iclass_t iclass;
    logic en_status;
    reg_idx_t rn;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rm;
    shift_t shift_op;
    imm5_t imm5;
    imm12_t imm12;
    imm24_t imm24;
    logic p;
    logic u;
    logic w;

    integer seed = 32'hd980;
    instr_t imem_table [0:63];
    int delay_tab [0:63];       // Ack latency per request
    int wait_cnt;
    logic [5:0] ack_count;

    addr_t exp_q [$];           // Next expected fetch address
    logic last_stall = 1'b0;
    logic last_redirect = 1'b0;
    addr_t last_target = '0;
    logic req_seen = 1'b0;
    int words_seen = 0;
    int checks = 0;
    int errors = 0;
    int err_base = 0;
    int pass_count = 0;
    int fail_count = 0;
    int cycles = 0;

    frontend_top uut (
        .clk(clk), .rst_n(rst_n), .stall(stall), .redirect(redirect),
        .redirect_target(redirect_target), .imem_ack(imem_ack), .imem_rdata(imem_rdata),
        .imem_req(imem_req), .imem_addr(imem_addr), .instr_out(instr_out),
        .cond(cond), .opcode(opcode), .iclass(iclass), .en_status(en_status),
        .rn(rn), .rd(rd), .rs(rs), .rm(rm), .shift_op(shift_op),
        .imm5(imm5), .imm12(imm12), .imm24(imm24), .p(p), .u(u), .w(w)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Four-phase memory, answer after the tabled delay
    always @(posedge clk) begin
        if (!rst_n) begin
            imem_ack <= 1'b0;
            wait_cnt <= 0;
            ack_count <= '0;
        end else if (imem_req && !imem_ack) begin
            if (wait_cnt >= delay_tab[ack_count]) begin
                imem_ack <= 1'b1;
                imem_rdata <= imem_table[imem_addr[7:2]];
                wait_cnt <= 0;
                ack_count <= ack_count + 6'd1;
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end else if (!imem_req && imem_ack) begin
            imem_ack <= 1'b0;
        end
    end

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_fields(input instr_t wd);
        logic is_dp;
        logic is_ls;
        is_dp = (wd[27:26] == 2'b00);
        is_ls = (wd[27:26] == 2'b01);
        expect_value("cond", 32'(cond), 32'(wd[31:28]));
        expect_value("opcode", 32'(opcode), 32'(wd[27:21]));
        expect_value("iclass", 32'(iclass), 32'(wd[27:26]));
        expect_value("rn", 32'(rn), 32'(wd[19:16]));
        expect_value("rd", 32'(rd), 32'(wd[15:12]));
        expect_value("rs", 32'(rs), 32'(wd[11:8]));
        expect_value("rm", 32'(rm), 32'(wd[3:0]));
        expect_value("shift_op", 32'(shift_op), 32'(wd[6:5]));
        expect_value("imm5", 32'(imm5), 32'(wd[11:7]));
        expect_value("imm12", 32'(imm12), 32'(wd[11:0]));
        expect_value("imm24", 32'(imm24), 32'(wd[23:0]));
        expect_value("en_status", 32'(en_status), is_dp ? 32'(wd[20]) : 32'h0);
        expect_value("p", 32'(p), is_ls ? 32'(wd[24]) : 32'h0);
        expect_value("u", 32'(u), is_ls ? 32'(wd[23]) : 32'h0);
        expect_value("w", 32'(w), is_ls ? 32'(wd[21]) : 32'h0);
    endtask

    // Outputs settle before the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            expect_value("imem_req", 32'(imem_req), 32'h0);
            expect_value("instr_out", instr_out, `FE_NOP_INSTR);
            exp_q.delete();
            exp_q.push_back(`FE_RESET_PC);
        end else begin
            if (!req_seen) begin
                expect_value("instr_out", instr_out, `FE_NOP_INSTR);
                if (imem_req) begin
                    expect_value("imem_addr", imem_addr, `FE_RESET_PC);
                    req_seen = 1'b1;
                end
            end
            if (last_redirect) begin
                expect_value("instr_out", instr_out, `FE_NOP_INSTR);
                exp_q.delete();
                exp_q.push_back(last_target);
            end else if (!last_stall && instr_out != `FE_NOP_INSTR) begin
                expect_value("instr_out", instr_out, imem_table[exp_q[0][7:2]]);
                check_fields(imem_table[exp_q[0][7:2]]);
                exp_q.push_back(exp_q.pop_front() + 32'd4);
                words_seen++;
            end
        end
        last_stall = stall;     // In effect at the next rising edge
        last_redirect = redirect;
        last_target = redirect_target;
    end

    task automatic wait_words(input int n);
        int target;
        target = words_seen + n;
        while (words_seen < target) @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        if (errors == err_base) begin
            $display("test %-36s ok", name);
            pass_count++;
        end else begin
            $display("test %-36s FAILED, %0d errors", name, errors - err_base);
            fail_count++;
        end
        err_base = errors;
    endtask

    function automatic addr_t random_target();
        logic [31:0] r;
        r = $random(seed);
        return {24'h0, r[7:2], 2'b00};
    endfunction

    task automatic pulse_redirect(input addr_t target);
        @(posedge clk);
        redirect <= 1'b1;
        redirect_target <= target;
        @(posedge clk);
        redirect <= 1'b0;
    endtask

    initial begin
        instr_t wd;
        logic [31:0] r;
        int i;
        for (i = 0; i < 64; i++) begin
            wd = $random(seed);
            wd[31:28] = 4'hE;
            if (wd == `FE_NOP_INSTR) wd[0] = ~wd[0];
            imem_table[i] = wd;
            r = $random(seed);
            delay_tab[i] = int'(r[1:0]);
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        while (!req_seen) @(posedge clk);
        wait_words(4);
        finish_test("reset");
        wait_words(30);
        finish_test("sequential fetch and decode");
        @(posedge clk);
        stall <= 1'b1;
        repeat (8) @(posedge clk);
        stall <= 1'b0;
        repeat (40) begin
            @(posedge clk);
            stall <= ($random(seed) & 3) != 0;
        end
        @(posedge clk);
        stall <= 1'b0;
        wait_words(6);
        finish_test("stall");
        pulse_redirect(random_target());
        wait_words(6);
        finish_test("redirect");
        @(negedge clk);
        while (!(imem_req && !imem_ack)) @(negedge clk);
        pulse_redirect(random_target());
        wait_words(6);
        finish_test("redirect with request outstanding");
        @(posedge clk);
        stall <= 1'b1;
        repeat (5) @(posedge clk);
        pulse_redirect(random_target());
        repeat (3) @(posedge clk);
        stall <= 1'b0;
        wait_words(6);
        finish_test("redirect during stall");
        $display("tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 pass_count, fail_count, checks, errors);
        if (errors == 0 && fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/frontend_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fe_settings.svh"

module frontend_chk (
    input wire                  clk,
    input wire                  rst_n,
    input wire                  stall,
    input wire                  redirect,
    input wire                  imem_req,
    input wire                  imem_ack,
    input wire fe_pkg::addr_t   imem_addr,
    input wire fe_pkg::instr_t  instr_out,
    input wire fe_pkg::iclass_t iclass,
    input wire                  en_status,
    input wire                  p,
    input wire                  u,
    input wire                  w
);

    // Request held until the memory answers
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req && !imem_ack |=> imem_req)
        else $error("imem_req dropped before imem_ack");

    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req |=> !imem_req || $stable(imem_addr))
        else $error("imem_addr changed during a request");

    req_falls: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req && imem_ack |=> !imem_req)
        else $error("imem_req still high after imem_ack");

    // Ack as seen on the edge that raised the request
    no_rise_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(imem_req) |-> !$past(imem_ack))
        else $error("imem_req rose while imem_ack high");

    // Decode stage frozen, a redirect still squashes
    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall && !redirect |=> $stable(instr_out) && $stable(iclass) &&
                               $stable({en_status, p, u, w}))
        else $error("decode outputs moved during stall");

    squash: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> instr_out == `FE_NOP_INSTR)
        else $error("old-path word visible after redirect");

endmodule

bind frontend_top frontend_chk chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .redirect  (redirect),
    .imem_req  (imem_req),
    .imem_ack  (imem_ack),
    .imem_addr (imem_addr),
    .instr_out (instr_out),
    .iclass    (iclass),
    .en_status (en_status),
    .p         (p),
    .u         (u),
    .w         (w)
);

`default_nettype wire

/* verilog/frontend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  stall,
    input  wire                  redirect,
    input  wire fe_pkg::addr_t   redirect_target,
    input  wire                  imem_ack,
    input  wire fe_pkg::instr_t  imem_rdata,
    output logic                 imem_req,
    output fe_pkg::addr_t        imem_addr,
    output fe_pkg::instr_t       instr_out,
    output fe_pkg::cond_t        cond,
    output fe_pkg::opcode_t      opcode,
    output fe_pkg::iclass_t      iclass,
    output logic                 en_status,
    output fe_pkg::reg_idx_t     rn,
    output fe_pkg::reg_idx_t     rd,
    output fe_pkg::reg_idx_t     rs,
    output fe_pkg::reg_idx_t     rm,
    output fe_pkg::shift_t       shift_op,
    output fe_pkg::imm5_t        imm5,
    output fe_pkg::imm12_t       imm12,
    output fe_pkg::imm24_t       imm24,
    output logic                 p,
    output logic                 u,
    output logic                 w
);
    import fe_pkg::*;

    instr_t fetch_instr;
    logic   fetch_epoch;
    logic   cur_epoch;

    fetch_unit u_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (stall),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .imem_ack        (imem_ack),
        .imem_rdata      (imem_rdata),
        .imem_req        (imem_req),
        .imem_addr       (imem_addr),
        .fetch_instr     (fetch_instr),
        .fetch_epoch     (fetch_epoch),
        .cur_epoch       (cur_epoch)
    );

    // Stored epoch is internal to the front end
    pipeline_unit u_pipe (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_in     (fetch_instr),
        .branch_in    (fetch_epoch),
        .branch_ref   (cur_epoch),
        .sel_stall    (stall),
        .instr_out    (instr_out),
        .branch_value (),
        .cond         (cond),
        .opcode       (opcode),
        .iclass       (iclass),
        .en_status    (en_status),
        .rn           (rn),
        .rd           (rd),
        .rs           (rs),
        .rm           (rm),
        .shift_op     (shift_op),
        .imm5         (imm5),
        .imm12        (imm12),
        .imm24        (imm24),
        .p            (p),
        .u            (u),
        .w            (w)
    );

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fe_settings.svh"

module fetch_unit (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  stall,
    input  wire                  redirect,
    input  wire fe_pkg::addr_t   redirect_target,
    input  wire                  imem_ack,
    input  wire fe_pkg::instr_t  imem_rdata,
    output logic                 imem_req,
    output fe_pkg::addr_t        imem_addr,
    output fe_pkg::instr_t       fetch_instr,
    output logic                 fetch_epoch,
    output logic                 cur_epoch
);
    import fe_pkg::*;

    fetch_state_t state_q;

    addr_t  pc_q;
    addr_t  req_addr_q;     // Address held for the whole request
    logic   req_epoch_q;    // Epoch tag of the outstanding request
    logic   epoch_q;

    logic   buf_valid_q;
    instr_t buf_instr_q;
    logic   buf_epoch_q;

    logic   fill;
    logic   issue;

    // Matching ack, word goes into the buffer
    assign fill = (state_q == REQ) && imem_ack && !redirect && (req_epoch_q == epoch_q);

    // Ack must be low and the buffer free or leaving on this edge
    assign issue = ((state_q == IDLE) || (state_q == WAIT_ACK_LOW)) && !imem_ack &&
                   (!buf_valid_q || !stall || redirect);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            epoch_q <= 1'b0;
        end else if (redirect) begin
            epoch_q <= ~epoch_q;    // Older words become stale
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `FE_RESET_PC;
        end else if (redirect) begin
            pc_q <= redirect_target;
        end else if (fill) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // A request issued on the redirect edge already belongs to the new path
    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr_q  <= redirect ? redirect_target : pc_q;
            req_epoch_q <= redirect ? ~epoch_q : epoch_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (issue) state_q <= REQ;
                end
                REQ: begin
                    if (imem_ack) begin
                        state_q <= WAIT_ACK_LOW;
                    end else if (redirect) begin
                        state_q <= DROP;    // Finish the handshake, discard data
                    end
                end
                DROP: begin
                    if (imem_ack) state_q <= WAIT_ACK_LOW;
                end
                WAIT_ACK_LOW: begin
                    if (issue) begin
                        state_q <= REQ;
                    end else if (!imem_ack) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // One-entry buffer, consumed on every stall-low edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid_q <= 1'b0;
        end else if (redirect) begin
            buf_valid_q <= 1'b0;
        end else if (fill) begin
            buf_valid_q <= 1'b1;
        end else if (!stall) begin
            buf_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            buf_instr_q <= imem_rdata;
            buf_epoch_q <= req_epoch_q;
        end
    end

    assign imem_req    = (state_q == REQ) || (state_q == DROP);
    assign imem_addr   = req_addr_q;
    assign fetch_instr = buf_valid_q ? buf_instr_q : `FE_NOP_INSTR;
    assign fetch_epoch = buf_valid_q ? buf_epoch_q : epoch_q;   // Empty slot is a plain NOP
    assign cur_epoch   = epoch_q;

endmodule

`default_nettype wire

/* verilog/pipeline_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fe_settings.svh"

module pipeline_unit (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire fe_pkg::instr_t  instr_in,
    input  wire                  branch_in,     // Epoch of instr_in
    input  wire                  branch_ref,    // Current epoch
    input  wire                  sel_stall,
    output fe_pkg::instr_t       instr_out,
    output logic                 branch_value,
    output fe_pkg::cond_t        cond,
    output fe_pkg::opcode_t      opcode,
    output fe_pkg::iclass_t      iclass,
    output logic                 en_status,
    output fe_pkg::reg_idx_t     rn,
    output fe_pkg::reg_idx_t     rd,
    output fe_pkg::reg_idx_t     rs,
    output fe_pkg::reg_idx_t     rm,
    output fe_pkg::shift_t       shift_op,
    output fe_pkg::imm5_t        imm5,
    output fe_pkg::imm12_t       imm12,
    output fe_pkg::imm24_t       imm24,
    output logic                 p,
    output logic                 u,
    output logic                 w
);
    import fe_pkg::*;

    instr_t instr_q;
    logic   epoch_q;
    instr_t dec_instr;

    // Word and its epoch move together, held while stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_q <= `FE_NOP_INSTR;
            epoch_q <= 1'b0;
        end else if (!sel_stall) begin
            instr_q <= instr_in;
            epoch_q <= branch_in;
        end
    end

    // Squash a word fetched before the last redirect
    assign dec_instr    = (epoch_q == branch_ref) ? instr_q : `FE_NOP_INSTR;
    assign instr_out    = dec_instr;
    assign branch_value = epoch_q;

    idecoder u_idecoder (
        .instr     (dec_instr),
        .cond      (cond),
        .opcode    (opcode),
        .iclass    (iclass),
        .en_status (en_status),
        .rn        (rn),
        .rd        (rd),
        .rs        (rs),
        .rm        (rm),
        .shift_op  (shift_op),
        .imm5      (imm5),
        .imm12     (imm12),
        .imm24     (imm24),
        .p         (p),
        .u         (u),
        .w         (w)
    );

endmodule

`default_nettype wire

/* verilog/idecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module idecoder (
    input  wire fe_pkg::instr_t  instr,
    output fe_pkg::cond_t        cond,
    output fe_pkg::opcode_t      opcode,
    output fe_pkg::iclass_t      iclass,
    output logic                 en_status,
    output fe_pkg::reg_idx_t     rn,
    output fe_pkg::reg_idx_t     rd,
    output fe_pkg::reg_idx_t     rs,
    output fe_pkg::reg_idx_t     rm,
    output fe_pkg::shift_t       shift_op,
    output fe_pkg::imm5_t        imm5,
    output fe_pkg::imm12_t       imm12,
    output fe_pkg::imm24_t       imm24,
    output logic                 p,
    output logic                 u,
    output logic                 w
);
    import fe_pkg::*;

    iclass_t cls;
    logic    is_dp;
    logic    is_ldst;

    assign cls     = instr[27:26];
    assign is_dp   = (cls == ICLASS_DP);
    assign is_ldst = (cls == ICLASS_LDST);

    // Fixed-position fields, valid whatever the class
    assign cond     = instr[31:28];
    assign opcode   = instr[27:21];
    assign iclass   = cls;

    assign rn       = instr[19:16];
    assign rd       = instr[15:12];
    assign rs       = instr[11:8];
    assign rm       = instr[3:0];

    assign shift_op = instr[6:5];
    assign imm5     = instr[11:7];      // Shift amount for register operand
    assign imm12    = instr[11:0];
    assign imm24    = instr[23:0];      // Word offset for B/BL

    // S bit only means something for data processing
    assign en_status = is_dp ? instr[20] : 1'b0;

    // Pre-index, up/down and writeback for loads and stores
    assign p = is_ldst ? instr[24] : 1'b0;
    assign u = is_ldst ? instr[23] : 1'b0;
    assign w = is_ldst ? instr[21] : 1'b0;

endmodule

`default_nettype wire

/* verilog/fe_pkg.sv */
`default_nettype none

package fe_pkg;

    typedef logic [31:0] instr_t;    // Raw instruction word
    typedef logic [31:0] addr_t;     // Byte address

    typedef logic [3:0]  cond_t;
    typedef logic [6:0]  opcode_t;   // Bits 27..21
    typedef logic [3:0]  reg_idx_t;
    typedef logic [1:0]  shift_t;

    typedef logic [4:0]  imm5_t;     // Shift amount
    typedef logic [11:0] imm12_t;    // Operand 2 or offset
    typedef logic [23:0] imm24_t;    // Branch offset

    // Instruction class, taken from bits 27..26
    typedef logic [1:0]  iclass_t;

    localparam iclass_t ICLASS_DP     = 2'b00;
    localparam iclass_t ICLASS_LDST   = 2'b01;
    localparam iclass_t ICLASS_BRANCH = 2'b10;
    localparam iclass_t ICLASS_OTHER  = 2'b11;

    // Fetch FSM for the instruction memory handshake
    typedef enum logic [1:0] {
        IDLE,
        REQ,            // Request out, waiting for ack
        DROP,           // Request out, result will be discarded
        WAIT_ACK_LOW
    } fetch_state_t;

endpackage

`default_nettype wire

/* verilog/fe_settings.svh */
`ifndef FE_SETTINGS_SVH
`define FE_SETTINGS_SVH

// First fetch address out of reset
`define FE_RESET_PC 32'h0000_0000

// Architectural NOP, cond AL with MSR-hint encoding
`define FE_NOP_INSTR 32'hE320_F000

`endif
